// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbCpuFrontEnd
FILELIST ?= all.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= No errors

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== all.f ====
verilog/cpuOpsPkg.sv
verilog/cpuBusPkg.sv
verilog/decodeIf.sv
verilog/opcodeDecoder.sv
verilog/cycleTimer.sv
verilog/fetchSequencer.sv
verilog/cpuFrontEnd.sv
tests/tbCpuFrontEnd.sv

// ==== tests/tbCpuFrontEnd.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbCpuFrontEnd;
    import cpuOpsPkg::*;
    import cpuBusPkg::*;

    localparam int issueTarget = 2000;
    localparam int resetAtIssue = 1000;
    // 11 cycles per issue exceeds the longest period and covers both resets
    localparam int timeoutCycles = issueTarget * 11 + 200;

    logic clk = 1'b0;
    logic arstN = 1'b0;
    logic [dataW-1:0] memData = '0;
    logic [addrW-1:0] memAddr;
    logic memRead;
    logic issue;
    logic [addrW-1:0] issuePc;
    cmdT issueCmd;
    modeT issueMode;
    logic [2*dataW-1:0] issueOperand;

    logic [dataW-1:0] mem [0:65535];
    int cyc = 0;
    int issueCount = 0;
    int checkCount = 0;
    int errorCount = 0;

    // model state
    logic [addrW-1:0] expAddr;
    logic [addrW-1:0] mPc;
    int expFetchCyc = 0;
    int expIssueCyc = 0;

    cpuFrontEnd u_dut (
        .clk          (clk),
        .arstN        (arstN),
        .memData      (memData),
        .memAddr      (memAddr),
        .memRead      (memRead),
        .issue        (issue),
        .issuePc      (issuePc),
        .issueCmd     (issueCmd),
        .issueMode    (issueMode),
        .issueOperand (issueOperand)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    // memory answers one cycle after the read strobe
    always @(posedge clk) begin
        if (memRead) begin
            memData <= mem[memAddr];
        end
    end

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checkCount = checkCount + 1;
        if (actual !== expected) begin
            errorCount = errorCount + 1;
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // reference decode takes regular groups by field and the rest by opcode
    task automatic decodeRef(input logic [7:0] op, output cmdT c, output modeT m);
        logic [2:0] a;
        logic [2:0] b;
        a = op[7:5];
        b = op[4:2];
        c = cmdIll;
        m = modeImpl;
        if (op[1:0] == 2'b01) begin
            case (a)
                3'd0: c = cmdOra;
                3'd1: c = cmdAnd;
                3'd2: c = cmdEor;
                3'd3: c = cmdAdc;
                3'd4: c = cmdSta;
                3'd5: c = cmdLda;
                3'd6: c = cmdCmp;
                default: c = cmdSbc;
            endcase
            case (b)
                3'd0: m = modeXind;
                3'd1: m = modeZpg;
                3'd2: m = modeImm;
                3'd3: m = modeAbs;
                3'd4: m = modeIndY;
                3'd5: m = modeZpgX;
                3'd6: m = modeAbsY;
                default: m = modeAbsX;
            endcase
            if (op == 8'h89) begin
                c = cmdIll;
                m = modeImpl;
            end
        end else if (op[1:0] == 2'b10 && (b[0] || (b == 3'd2 && !a[2]))) begin
            case (a)
                3'd0: c = cmdAsl;
                3'd1: c = cmdRol;
                3'd2: c = cmdLsr;
                3'd3: c = cmdRor;
                3'd4: c = cmdStx;
                3'd5: c = cmdLdx;
                3'd6: c = cmdDec;
                default: c = cmdInc;
            endcase
            case (b)
                3'd1: m = modeZpg;
                3'd2: m = modeAcc;
                3'd3: m = modeAbs;
                3'd5: m = modeZpgX;
                default: m = modeAbsX;
            endcase
            if (op == 8'h96 || op == 8'hB6) begin
                m = modeZpgY;
            end
            if (op == 8'hBE) begin
                m = modeAbsY;
            end
            // no STX absolute,Y
            if (op == 8'h9E) begin
                c = cmdIll;
                m = modeImpl;
            end
        end else begin
            case (op)
                8'h00: c = cmdBrk;
                8'h20: c = cmdJsr;
                8'h40: c = cmdRti;
                8'h60: c = cmdRts;
                8'h24, 8'h2C: c = cmdBit;
                8'h4C, 8'h6C: c = cmdJmp;
                8'h84, 8'h8C, 8'h94: c = cmdSty;
                8'hA0, 8'hA4, 8'hAC, 8'hB4, 8'hBC: c = cmdLdy;
                8'hC0, 8'hC4, 8'hCC: c = cmdCpy;
                8'hE0, 8'hE4, 8'hEC: c = cmdCpx;
                8'h08: c = cmdPhp;
                8'h28: c = cmdPlp;
                8'h48: c = cmdPha;
                8'h68: c = cmdPla;
                8'h88: c = cmdDey;
                8'hA8: c = cmdTay;
                8'hC8: c = cmdIny;
                8'hE8: c = cmdInx;
                8'h10: c = cmdBpl;
                8'h30: c = cmdBmi;
                8'h50: c = cmdBvc;
                8'h70: c = cmdBvs;
                8'h90: c = cmdBcc;
                8'hB0: c = cmdBcs;
                8'hD0: c = cmdBne;
                8'hF0: c = cmdBeq;
                8'h18: c = cmdClc;
                8'h38: c = cmdSec;
                8'h58: c = cmdCli;
                8'h78: c = cmdSei;
                8'h98: c = cmdTya;
                8'hB8: c = cmdClv;
                8'hD8: c = cmdCld;
                8'hF8: c = cmdSed;
                8'hA2: c = cmdLdx;
                8'h8A: c = cmdTxa;
                8'hAA: c = cmdTax;
                8'hCA: c = cmdDex;
                8'hEA: c = cmdNop;
                8'h9A: c = cmdTxs;
                8'hBA: c = cmdTsx;
                default: c = cmdIll;
            endcase
            case (op)
                8'h20, 8'h2C, 8'h4C, 8'h8C, 8'hAC, 8'hCC, 8'hEC: m = modeAbs;
                8'h6C: m = modeInd;
                8'hA0, 8'hC0, 8'hE0, 8'hA2: m = modeImm;
                8'h24, 8'h84, 8'hA4, 8'hC4, 8'hE4: m = modeZpg;
                8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: m = modeRel;
                8'h94, 8'hB4: m = modeZpgX;
                8'hBC: m = modeAbsX;
                default: m = modeImpl;
            endcase
        end
    endtask

    function automatic int lengthOf(modeT m);
        case (m)
            modeAcc, modeImpl: return 1;
            modeAbs, modeAbsX, modeAbsY, modeInd: return 3;
            default: return 2;
        endcase
    endfunction

    function automatic int addrWaits(modeT m);
        case (m)
            modeZpgX, modeZpgY, modeAbsX, modeAbsY, modeIndY: return 1;
            modeInd, modeXind: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic int opWaits(cmdT c, modeT m);
        case (c)
            cmdAsl, cmdRol, cmdLsr, cmdRor, cmdInc, cmdDec: return (m == modeAcc) ? 0 : 2;
            cmdPla, cmdPlp, cmdRts, cmdRti: return 2;
            cmdPha, cmdPhp, cmdJsr, cmdBrk: return 1;
            default: return 0;
        endcase
    endfunction

    task automatic predict(input logic [addrW-1:0] pc, output cmdT c, output modeT m,
                           output int len, output int waits);
        decodeRef(mem[pc], c, m);
        len = lengthOf(m);
        waits = addrWaits(m) + opWaits(c, m);
    endtask

    task automatic holdReset();
        @(posedge clk);
        arstN <= 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        cmdT c;
        modeT m;
        int len;
        int waits;
        logic [2*dataW-1:0] operand;
        cyc = cyc + 1;
        if (!arstN) begin
            checkVal("memRead", 32'd0, 32'(memRead));
            checkVal("issue", 32'd0, 32'(issue));
            expAddr = resetPc;
            mPc = resetPc;
            predict(resetPc, c, m, len, waits);
            expFetchCyc = cyc + 2;
            expIssueCyc = expFetchCyc + 1 + len + waits;
        end else begin
            if (cyc < expFetchCyc) begin
                checkVal("memRead", 32'd0, 32'(memRead));
                checkVal("issue", 32'd0, 32'(issue));
            end
            if (cyc == expFetchCyc) begin
                checkVal("memRead", 32'd1, 32'(memRead));
            end
            // reads walk the program byte by byte
            if (memRead) begin
                checkVal("memAddr", 32'(expAddr), 32'(memAddr));
                expAddr = expAddr + 16'd1;
            end
            if (issue) begin
                predict(mPc, c, m, len, waits);
                case (len)
                    1: operand = '0;
                    2: operand = {8'h00, mem[mPc + 16'd1]};
                    default: operand = {mem[mPc + 16'd2], mem[mPc + 16'd1]};
                endcase
                checkVal("issue cycle", 32'(expIssueCyc), 32'(cyc));
                checkVal("issuePc", 32'(mPc), 32'(issuePc));
                checkVal("issueCmd", 32'(c), 32'(issueCmd));
                checkVal("issueMode", 32'(m), 32'(issueMode));
                checkVal("issueOperand", 32'(operand), 32'(issueOperand));
                issueCount = issueCount + 1;
                mPc = mPc + 16'(len);
                // issue cycle doubles as the next fetch
                predict(mPc, c, m, len, waits);
                expIssueCyc = cyc + 1 + len + waits;
            end else if (cyc == expIssueCyc) begin
                errorCount = errorCount + 1;
                $display("missing issue pulse at %0t for the instruction at %0h", $time, mPc);
            end
        end
    end

    initial begin : watchdog
        wait (cyc >= timeoutCycles);
        $display("timeout after %0d cycles, only %0d of %0d instructions issued",
                 cyc, issueCount, issueTarget);
        $display("%0d issues, %0d checks, %0d errors", issueCount, checkCount, errorCount);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        int i;
        void'($urandom(32'h126c_426d));
        for (i = 0; i < 65536; i = i + 1) begin
            mem[i] = 8'($urandom);
        end
        holdReset();
        wait (issueCount >= resetAtIssue);
        // land the reset inside an instruction
        repeat (3) @(posedge clk);
        holdReset();
        wait (issueCount >= issueTarget);
        $display("%0d issues, %0d checks, %0d errors", issueCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cpuBusPkg.sv ====
`default_nettype none

package cpuBusPkg;

    localparam int addrW = 16;
    localparam int dataW = 8;

    // first opcode fetch after reset
    localparam logic [addrW-1:0] resetPc = 16'h0200;

    localparam int lenW = 2;

    // instruction lengths by mode group
    // acc and implied
    localparam logic [lenW-1:0] lenOne = 2'd1;
    // immediate, relative, zero page and the indirect-indexed forms
    localparam logic [lenW-1:0] lenTwo = 2'd2;
    // abs, absX, absY and ind
    localparam logic [lenW-1:0] lenThree = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/cpuFrontEnd.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuFrontEnd (
    input  wire                            clk,
    input  wire                            arstN,
    input  wire  [cpuBusPkg::dataW-1:0]    memData,
    output logic [cpuBusPkg::addrW-1:0]    memAddr,
    output logic                           memRead,
    output logic                           issue,
    output logic [cpuBusPkg::addrW-1:0]    issuePc,
    output cpuOpsPkg::cmdT                 issueCmd,
    output cpuOpsPkg::modeT                issueMode,
    output logic [2*cpuBusPkg::dataW-1:0]  issueOperand
);
    import cpuBusPkg::*;

    logic [dataW-1:0] opcode;
    logic waitStart;
    logic waitDone;

    decodeIf decBus ();

    opcodeDecoder u_decoder (
        .opcode (opcode),
        .dec    (decBus)
    );

    cycleTimer u_timer (
        .clk       (clk),
        .arstN     (arstN),
        .tim       (decBus),
        .waitStart (waitStart),
        .waitDone  (waitDone)
    );

    fetchSequencer u_sequencer (
        .clk          (clk),
        .arstN        (arstN),
        .memData      (memData),
        .memAddr      (memAddr),
        .memRead      (memRead),
        .opcode       (opcode),
        .seq          (decBus),
        .waitStart    (waitStart),
        .waitDone     (waitDone),
        .issue        (issue),
        .issuePc      (issuePc),
        .issueCmd     (issueCmd),
        .issueMode    (issueMode),
        .issueOperand (issueOperand)
    );

endmodule

`default_nettype wire

// ==== verilog/cpuOpsPkg.sv ====
`default_nettype none

package cpuOpsPkg;

    localparam int timingW = 3;

    // the 56 documented NMOS mnemonics plus cmdIll for the holes
    typedef enum logic [5:0] {
        cmdIll,
        cmdAdc, cmdAnd, cmdAsl, cmdBcc, cmdBcs, cmdBeq,
        cmdBit, cmdBmi, cmdBne, cmdBpl, cmdBrk, cmdBvc,
        cmdBvs, cmdClc, cmdCld, cmdCli, cmdClv, cmdCmp,
        cmdCpx, cmdCpy, cmdDec, cmdDex, cmdDey, cmdEor,
        cmdInc, cmdInx, cmdIny, cmdJmp, cmdJsr, cmdLda,
        cmdLdx, cmdLdy, cmdLsr, cmdNop, cmdOra, cmdPha,
        cmdPhp, cmdPla, cmdPlp, cmdRol, cmdRor, cmdRti,
        cmdRts, cmdSbc, cmdSec, cmdSed, cmdSei, cmdSta,
        cmdStx, cmdSty, cmdTax, cmdTay, cmdTsx, cmdTxa,
        cmdTxs, cmdTya
    } cmdT;

    typedef enum logic [3:0] {
        modeAcc,
        modeImm,
        modeImpl,
        modeRel,
        modeZpg,
        modeZpgX,
        modeZpgY,
        modeAbs,
        modeAbsX,
        modeAbsY,
        modeInd,
        modeXind,
        modeIndY
    } modeT;

    // addressing waits
    // direct modes need no extra cycle
    localparam logic [timingW-1:0] addrWaitDirect = 3'd0;
    // one cycle for the index add in every indexed mode
    localparam logic [timingW-1:0] addrWaitIndexed = 3'd1;
    // pointer fetch for ind and Xind
    localparam logic [timingW-1:0] addrWaitIndirect = 3'd2;

    // operation waits
    localparam logic [timingW-1:0] opWaitNone = 3'd0;
    // stack push of PHA, PHP, JSR and BRK
    localparam logic [timingW-1:0] opWaitPush = 3'd1;
    // stack pull and return
    localparam logic [timingW-1:0] opWaitPull = 3'd2;
    // read, modify, write back to memory
    localparam logic [timingW-1:0] opWaitRmw = 3'd2;

endpackage

`default_nettype wire

// ==== verilog/cycleTimer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cycleTimer (
    input  wire       clk,
    input  wire       arstN,
    decodeIf.timer    tim,
    input  wire       waitStart,
    output logic      waitDone
);
    import cpuOpsPkg::*;

    typedef enum logic [1:0] {
        idle,
        counting,
        done
    } stateT;

    stateT state;
    logic [timingW:0] count;
    logic [timingW:0] total;

    // one extra bit keeps the carry of the sum
    assign total = tim.addrTiming + tim.opTiming;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                counting: begin
                    count <= count - 1'b1;
                    if (count == 1) begin
                        state <= done;
                    end
                end
                default: begin
                    if (waitStart) begin
                        count <= total;
                        // zero waits finish the cycle after the start
                        state <= (total == '0) ? done : counting;
                    end else begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    assign waitDone = (state == done);

endmodule

`default_nettype wire

// ==== verilog/decodeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decodeIf;
    import cpuOpsPkg::*;
    import cpuBusPkg::*;

    // level values valid while the decoder's opcode is stable
    cmdT cmd;
    modeT mode;
    logic [lenW-1:0] length;
    logic [timingW-1:0] addrTiming;
    logic [timingW-1:0] opTiming;

    modport decoder (
        output cmd, mode, length, addrTiming, opTiming
    );

    modport sequencer (
        input cmd, mode, length
    );

    modport timer (
        input addrTiming, opTiming
    );

endinterface

`default_nettype wire

// ==== verilog/fetchSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetchSequencer (
    input  wire                            clk,
    input  wire                            arstN,
    input  wire  [cpuBusPkg::dataW-1:0]    memData,
    output logic [cpuBusPkg::addrW-1:0]    memAddr,
    output logic                           memRead,
    output logic [cpuBusPkg::dataW-1:0]    opcode,
    decodeIf.sequencer                     seq,
    output logic                           waitStart,
    input  wire                            waitDone,
    output logic                           issue,
    output logic [cpuBusPkg::addrW-1:0]    issuePc,
    output cpuOpsPkg::cmdT                 issueCmd,
    output cpuOpsPkg::modeT                issueMode,
    output logic [2*cpuBusPkg::dataW-1:0]  issueOperand
);
    import cpuBusPkg::*;

    typedef enum logic [2:0] {
        fetch,
        decode,
        operandLo,
        operandHi,
        waiting
    } stateT;

    stateT state;
    logic started;
    logic [addrW-1:0] pc;
    logic [addrW-1:0] instPc;
    logic [dataW-1:0] opcodeReg;
    logic [dataW-1:0] operandLoReg;
    logic [dataW-1:0] operandHiReg;
    logic fetchNow;
    logic moreBytes;

    // opcode fetch right after reset, or overlapped with the issue cycle
    assign fetchNow = (state == fetch && started) || (state == waiting && waitDone);
    assign moreBytes = (state == decode && seq.length > lenOne)
                    || (state == operandLo && seq.length == lenThree);

    assign memRead = fetchNow || moreBytes;
    assign memAddr = pc;
    assign waitStart = (state == decode || state == operandLo || state == operandHi)
                    && !moreBytes;
    assign issue = (state == waiting) && waitDone;

    // decoder sees the returning byte in decode, the held opcode afterwards
    assign opcode = (state == decode) ? memData : opcodeReg;

    assign issuePc = instPc;
    assign issueCmd = seq.cmd;
    assign issueMode = seq.mode;
    assign issueOperand = {operandHiReg, operandLoReg};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= fetch;
            started <= 1'b0;
            pc <= resetPc;
        end else begin
            started <= 1'b1;
            // one step per byte read
            if (memRead) begin
                pc <= pc + 1'b1;
            end
            case (state)
                fetch: begin
                    if (started) begin
                        state <= decode;
                    end
                end
                decode: state <= moreBytes ? operandLo : waiting;
                operandLo: state <= moreBytes ? operandHi : waiting;
                operandHi: state <= waiting;
                waiting: begin
                    if (waitDone) begin
                        state <= decode;
                    end
                end
                default: state <= fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetchNow) begin
            instPc <= pc;
        end
        if (state == decode) begin
            opcodeReg <= memData;
            operandLoReg <= '0;
            operandHiReg <= '0;
        end
        if (state == operandLo) begin
            operandLoReg <= memData;
        end
        if (state == operandHi) begin
            operandHiReg <= memData;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/opcodeDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module opcodeDecoder (
    input wire [cpuBusPkg::dataW-1:0] opcode,
    decodeIf.decoder                  dec
);
    import cpuOpsPkg::*;
    import cpuBusPkg::*;

    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
    cmdT grp1Cmd;
    cmdT grp2Cmd;
    cmdT grp3Cmd;
    cmdT cmd;
    modeT mode;
    logic [lenW-1:0] length;
    logic [timingW-1:0] addrTiming;
    logic [timingW-1:0] opTiming;

    assign aaa = opcode[7:5];
    assign bbb = opcode[4:2];
    assign cc = opcode[1:0];

    // command tables selected by aaa within each cc group
    always_comb begin
        case (aaa)
            3'b000: grp1Cmd = cmdOra;
            3'b001: grp1Cmd = cmdAnd;
            3'b010: grp1Cmd = cmdEor;
            3'b011: grp1Cmd = cmdAdc;
            3'b100: grp1Cmd = cmdSta;
            3'b101: grp1Cmd = cmdLda;
            3'b110: grp1Cmd = cmdCmp;
            default: grp1Cmd = cmdSbc;
        endcase
        case (aaa)
            3'b000: grp2Cmd = cmdAsl;
            3'b001: grp2Cmd = cmdRol;
            3'b010: grp2Cmd = cmdLsr;
            3'b011: grp2Cmd = cmdRor;
            3'b100: grp2Cmd = cmdStx;
            3'b101: grp2Cmd = cmdLdx;
            3'b110: grp2Cmd = cmdDec;
            default: grp2Cmd = cmdInc;
        endcase
        case (aaa)
            3'b001: grp3Cmd = cmdBit;
            3'b010: grp3Cmd = cmdJmp;
            3'b011: grp3Cmd = cmdJmp;
            3'b100: grp3Cmd = cmdSty;
            3'b101: grp3Cmd = cmdLdy;
            3'b110: grp3Cmd = cmdCpy;
            3'b111: grp3Cmd = cmdCpx;
            default: grp3Cmd = cmdIll;
        endcase
    end

    always_comb begin
        cmd = cmdIll;
        mode = modeImpl;
        case (cc)
            2'b01: begin
                cmd = grp1Cmd;
                case (bbb)
                    3'b000: mode = modeXind;
                    3'b001: mode = modeZpg;
                    3'b010: mode = modeImm;
                    3'b011: mode = modeAbs;
                    3'b100: mode = modeIndY;
                    3'b101: mode = modeZpgX;
                    3'b110: mode = modeAbsY;
                    default: mode = modeAbsX;
                endcase
                // no STA immediate
                if (aaa == 3'b100 && bbb == 3'b010) begin
                    cmd = cmdIll;
                    mode = modeImpl;
                end
            end
            2'b10: begin
                case (bbb)
                    3'b000: begin
                        if (aaa == 3'b101) begin
                            cmd = cmdLdx;
                            mode = modeImm;
                        end
                    end
                    3'b001: begin
                        cmd = grp2Cmd;
                        mode = modeZpg;
                    end
                    3'b010: begin
                        case (aaa)
                            3'b100: cmd = cmdTxa;
                            3'b101: cmd = cmdTax;
                            3'b110: cmd = cmdDex;
                            3'b111: cmd = cmdNop;
                            default: begin
                                cmd = grp2Cmd;
                                mode = modeAcc;
                            end
                        endcase
                    end
                    3'b011: begin
                        cmd = grp2Cmd;
                        mode = modeAbs;
                    end
                    3'b101: begin
                        cmd = grp2Cmd;
                        // STX and LDX index with Y
                        mode = (aaa[2:1] == 2'b10) ? modeZpgY : modeZpgX;
                    end
                    3'b110: begin
                        if (aaa == 3'b100) begin
                            cmd = cmdTxs;
                        end else if (aaa == 3'b101) begin
                            cmd = cmdTsx;
                        end
                    end
                    3'b111: begin
                        if (aaa != 3'b100) begin
                            cmd = grp2Cmd;
                            mode = (aaa == 3'b101) ? modeAbsY : modeAbsX;
                        end
                    end
                    default: ;
                endcase
            end
            2'b00: begin
                case (bbb)
                    3'b000: begin
                        case (aaa)
                            3'b000: cmd = cmdBrk;
                            3'b001: begin
                                cmd = cmdJsr;
                                mode = modeAbs;
                            end
                            3'b010: cmd = cmdRti;
                            3'b011: cmd = cmdRts;
                            3'b100: ;
                            default: begin
                                cmd = grp3Cmd;
                                mode = modeImm;
                            end
                        endcase
                    end
                    3'b001: begin
                        if (aaa == 3'b001 || aaa[2]) begin
                            cmd = grp3Cmd;
                            mode = modeZpg;
                        end
                    end
                    3'b010: begin
                        case (aaa)
                            3'b000: cmd = cmdPhp;
                            3'b001: cmd = cmdPlp;
                            3'b010: cmd = cmdPha;
                            3'b011: cmd = cmdPla;
                            3'b100: cmd = cmdDey;
                            3'b101: cmd = cmdTay;
                            3'b110: cmd = cmdIny;
                            default: cmd = cmdInx;
                        endcase
                    end
                    3'b011: begin
                        if (aaa != 3'b000) begin
                            cmd = grp3Cmd;
                            // 6C is the indirect jump
                            mode = (aaa == 3'b011) ? modeInd : modeAbs;
                        end
                    end
                    3'b100: begin
                        mode = modeRel;
                        case (aaa)
                            3'b000: cmd = cmdBpl;
                            3'b001: cmd = cmdBmi;
                            3'b010: cmd = cmdBvc;
                            3'b011: cmd = cmdBvs;
                            3'b100: cmd = cmdBcc;
                            3'b101: cmd = cmdBcs;
                            3'b110: cmd = cmdBne;
                            default: cmd = cmdBeq;
                        endcase
                    end
                    3'b101: begin
                        if (aaa[2:1] == 2'b10) begin
                            cmd = grp3Cmd;
                            mode = modeZpgX;
                        end
                    end
                    3'b110: begin
                        case (aaa)
                            3'b000: cmd = cmdClc;
                            3'b001: cmd = cmdSec;
                            3'b010: cmd = cmdCli;
                            3'b011: cmd = cmdSei;
                            3'b100: cmd = cmdTya;
                            3'b101: cmd = cmdClv;
                            3'b110: cmd = cmdCld;
                            default: cmd = cmdSed;
                        endcase
                    end
                    default: begin
                        if (aaa == 3'b101) begin
                            cmd = cmdLdy;
                            mode = modeAbsX;
                        end
                    end
                endcase
            end
            default: ;
        endcase
    end

    // length and wait codes
    always_comb begin
        case (mode)
            modeAcc, modeImpl: length = lenOne;
            modeAbs, modeAbsX, modeAbsY, modeInd: length = lenThree;
            default: length = lenTwo;
        endcase
        case (mode)
            modeZpgX, modeZpgY, modeAbsX, modeAbsY, modeIndY: addrTiming = addrWaitIndexed;
            modeInd, modeXind: addrTiming = addrWaitIndirect;
            default: addrTiming = addrWaitDirect;
        endcase
        case (cmd)
            cmdAsl, cmdRol, cmdLsr, cmdRor, cmdInc, cmdDec: begin
                // accumulator shifts stay in the core
                opTiming = (mode == modeAcc) ? opWaitNone : opWaitRmw;
            end
            cmdPla, cmdPlp, cmdRts, cmdRti: opTiming = opWaitPull;
            cmdPha, cmdPhp, cmdJsr, cmdBrk: opTiming = opWaitPush;
            default: opTiming = opWaitNone;
        endcase
    end

    assign dec.cmd = cmd;
    assign dec.mode = mode;
    assign dec.length = length;
    assign dec.addrTiming = addrTiming;
    assign dec.opTiming = opTiming;

endmodule

`default_nettype wire
